/* hw/fetchPkg.sv */
package fetchPkg;

    typedef logic [31:0] Addr_t;
    typedef logic [31:0] Instr_t;

    // Wraps modulo 16, one PC file entry per ID
    typedef logic [3:0] FetchId_t;

    localparam Addr_t RESET_PC = 32'h0000_0000;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef enum logic [1:0] {
        FAULT_NONE      = 2'd0,
        FAULT_INTERRUPT = 2'd1
    } FetchFault_t;

    typedef struct packed {
        Addr_t       pc;
        Instr_t      instr;
        FetchId_t    fetchId;
        logic        predTaken;
        FetchFault_t fault;
    } FetchOut_t;

    typedef struct packed {
        logic  taken;
        Addr_t dst;
    } Redirect_t;

    typedef struct packed {
        logic  valid;
        Addr_t src;
        Addr_t dst;
    } BtbUpdate_t;

    typedef struct packed {
        logic     valid;
        FetchId_t addr;
    } PcRead_t;

    typedef struct packed {
        Addr_t araddr;
    } AxiLiteAr_t;

    typedef struct packed {
        Instr_t     rdata;
        logic [1:0] rresp;
    } AxiLiteR_t;

    typedef struct packed {
        Addr_t      awaddr;
        Instr_t     wdata;
        logic [3:0] wstrb;
    } AxiLiteW_t;

endpackage

/* hw/branchPredictor.sv */
`timescale 1ns/1ps

module branchPredictor #(
    parameter int BTB_ENTRIES = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  fetchPkg::Redirect_t   redirect,
    input  fetchPkg::BtbUpdate_t  btbUpd,
    input  logic                  accept,
    output fetchPkg::Addr_t       pc,
    output logic                  predTaken
);

    localparam int IDX_W = $clog2(BTB_ENTRIES);
    localparam int TAG_W = 30 - IDX_W;

    typedef logic [IDX_W-1:0] BtbIdx_t;
    typedef logic [TAG_W-1:0] BtbTag_t;

    fetchPkg::Addr_t pcReg;
    fetchPkg::Addr_t pcNext;

    logic [BTB_ENTRIES-1:0] btbValid;
    BtbTag_t                btbTag [BTB_ENTRIES];
    fetchPkg::Addr_t        btbDst [BTB_ENTRIES];

    BtbIdx_t rdIdx;
    BtbIdx_t wrIdx;
    logic    hit;

    // Word address bits select the entry, the rest form the tag
    assign rdIdx = pcReg[IDX_W+1:2];
    assign wrIdx = btbUpd.src[IDX_W+1:2];

    assign hit = btbValid[rdIdx] && (btbTag[rdIdx] == pcReg[31:IDX_W+2]);

    assign pc        = pcReg;
    assign predTaken = hit;

    always_comb begin
        pcNext = pcReg;
        if (redirect.taken) begin
            pcNext = redirect.dst;
        end else if (accept) begin
            pcNext = hit ? btbDst[rdIdx] : pcReg + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pcReg <= fetchPkg::RESET_PC;
        end else begin
            pcReg <= pcNext;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            btbValid <= '0;
        end else if (btbUpd.valid) begin
            btbValid[wrIdx] <= 1'b1;
        end
    end

    // Tags and targets are qualified by btbValid
    always_ff @(posedge clk) begin
        if (btbUpd.valid) begin
            btbTag[wrIdx] <= btbUpd.src[31:IDX_W+2];
            btbDst[wrIdx] <= btbUpd.dst;
        end
    end

endmodule

/* hw/pcFile.sv */
`timescale 1ns/1ps

module pcFile (
    input  logic                clk,
    input  logic                rst,
    input  logic                we,
    input  fetchPkg::FetchId_t  waddr,
    input  fetchPkg::Addr_t     wdata,
    input  fetchPkg::PcRead_t   rdReq,
    output fetchPkg::Addr_t     rdData
);

    localparam int ENTRIES = 1 << $bits(fetchPkg::FetchId_t);

    fetchPkg::Addr_t    mem [ENTRIES];
    logic [ENTRIES-1:0] written;

    always_ff @(posedge clk) begin
        if (rst) begin
            written <= '0;
        end else if (we) begin
            written[waddr] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Back-end read port, entries never written read as the reset PC
    assign rdData = (rdReq.valid && written[rdReq.addr]) ? mem[rdReq.addr]
                                                         : fetchPkg::RESET_PC;

endmodule

/* hw/fetchPipeline.sv */
`timescale 1ns/1ps

module fetchPipeline (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetchEn,
    input  fetchPkg::Addr_t        pc,
    input  logic                   predTaken,
    input  fetchPkg::FetchFault_t  fault,
    input  logic                   squash,
    output logic                   accept,
    output logic                   arvalid,
    input  logic                   arready,
    output fetchPkg::AxiLiteAr_t   ar,
    input  logic                   rvalid,
    output logic                   rready,
    input  fetchPkg::AxiLiteR_t    r,
    output logic                   outValid,
    input  logic                   outReady,
    output fetchPkg::FetchOut_t    outInstr,
    output logic                   pcWe,
    output fetchPkg::FetchId_t     pcWaddr,
    output fetchPkg::Addr_t        pcWdata
);

    // Slot for the one fetch between issue and output buffer
    logic                  reqValid;
    logic                  reqRead;
    logic                  reqEpoch;
    fetchPkg::Addr_t       reqPc;
    logic                  reqPredTaken;
    fetchPkg::FetchFault_t reqFault;

    logic                  epoch;
    fetchPkg::FetchId_t    idCnt;
    fetchPkg::FetchOut_t   outBuf;

    logic                  isInterrupt;
    logic                  bufFree;
    logic                  stale;
    logic                  respAvail;
    logic                  respTake;
    logic                  issue;
    logic                  arFire;
    logic                  intIssue;
    logic                  deliver;
    logic                  xfer;
    fetchPkg::FetchId_t    loadId;
    fetchPkg::Instr_t      respWord;

    assign isInterrupt = (fault == fetchPkg::FAULT_INTERRUPT);
    assign bufFree     = !outValid || outReady;
    assign stale       = (reqEpoch != epoch);

    // Interrupt fetches have no bus read, their response is ready a cycle later
    assign respAvail = reqValid && (rvalid || !reqRead);
    assign respTake  = respAvail && (stale || bufFree);
    assign rready    = reqValid && reqRead && (stale || bufFree);

    assign issue    = fetchEn && !squash && bufFree && (!reqValid || respTake);
    assign arvalid  = issue && !isInterrupt;
    assign arFire   = arvalid && arready;
    assign intIssue = issue && isInterrupt;
    assign accept   = arFire || intIssue;
    assign ar       = fetchPkg::AxiLiteAr_t'{araddr: pc};

    assign deliver  = respTake && !stale && !squash;
    assign xfer     = outValid && outReady;
    assign respWord = reqRead ? r.rdata : '0;

    // The buffered item always holds the next ID to transfer
    assign loadId = xfer ? idCnt + 4'd1 : idCnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            reqValid <= 1'b0;
            epoch    <= 1'b0;
            outValid <= 1'b0;
            idCnt    <= '0;
        end else begin
            if (squash) begin
                epoch <= !epoch;
            end
            if (accept) begin
                reqValid <= 1'b1;
            end else if (respTake) begin
                reqValid <= 1'b0;
            end
            if (squash) begin
                outValid <= 1'b0;
            end else if (deliver) begin
                outValid <= 1'b1;
            end else if (xfer) begin
                outValid <= 1'b0;
            end
            if (xfer) begin
                idCnt <= idCnt + 4'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            reqRead      <= !isInterrupt;
            reqEpoch     <= epoch;
            reqPc        <= pc;
            reqPredTaken <= predTaken;
            reqFault     <= fault;
        end
        if (deliver) begin
            outBuf <= fetchPkg::FetchOut_t'{
                pc:        reqPc,
                instr:     respWord,
                fetchId:   loadId,
                predTaken: reqPredTaken,
                fault:     reqFault
            };
        end
    end

    assign outInstr = outBuf;

    assign pcWe    = xfer;
    assign pcWaddr = outBuf.fetchId;
    assign pcWdata = outBuf.pc;

endmodule

/* hw/iFetch.sv */
`timescale 1ns/1ps

module iFetch #(
    parameter int BTB_ENTRIES = 8,
    parameter int RESET_DELAY = 20
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  intPending,
    input  fetchPkg::Redirect_t   redirect,
    input  fetchPkg::BtbUpdate_t  btbUpd,
    output logic                  outValid,
    input  logic                  outReady,
    output fetchPkg::FetchOut_t   outInstr,
    input  fetchPkg::PcRead_t     pcRead,
    output fetchPkg::Addr_t       pcReadData,
    output logic                  arvalid,
    input  logic                  arready,
    output fetchPkg::AxiLiteAr_t  ar,
    input  logic                  rvalid,
    output logic                  rready,
    input  fetchPkg::AxiLiteR_t   r
);

    localparam int CNT_W = $clog2(RESET_DELAY + 1);

    fetchPkg::Addr_t       pc;
    logic                  predTaken;
    logic                  accept;
    logic                  fetchEn;
    fetchPkg::FetchFault_t fault;

    logic                  pcWe;
    fetchPkg::FetchId_t    pcWaddr;
    fetchPkg::Addr_t       pcWdata;

    logic                  waiting;
    logic [CNT_W-1:0]      waitCnt;
    logic                  issuedInterrupt;

    assign fault   = intPending ? fetchPkg::FAULT_INTERRUPT : fetchPkg::FAULT_NONE;
    assign fetchEn = !waiting && !issuedInterrupt && !redirect.taken;

    always_ff @(posedge clk) begin
        if (rst) begin
            waiting         <= 1'b1;
            waitCnt         <= CNT_W'(RESET_DELAY - 1);
            issuedInterrupt <= 1'b0;
        end else begin
            // Start-up wait, cut short by a pending interrupt
            if (waiting) begin
                waitCnt <= waitCnt - 1'b1;
                if (waitCnt == '0 || intPending) begin
                    waiting <= 1'b0;
                end
            end
            if (redirect.taken) begin
                issuedInterrupt <= 1'b0;
            end else if (accept && fault == fetchPkg::FAULT_INTERRUPT) begin
                issuedInterrupt <= 1'b1;
            end
        end
    end

    branchPredictor #(
        .BTB_ENTRIES(BTB_ENTRIES)
    ) branchPredictor_i (
        .clk      (clk),
        .rst      (rst),
        .redirect (redirect),
        .btbUpd   (btbUpd),
        .accept   (accept),
        .pc       (pc),
        .predTaken(predTaken)
    );

    fetchPipeline fetchPipeline_i (
        .clk      (clk),
        .rst      (rst),
        .fetchEn  (fetchEn),
        .pc       (pc),
        .predTaken(predTaken),
        .fault    (fault),
        .squash   (redirect.taken),
        .accept   (accept),
        .arvalid  (arvalid),
        .arready  (arready),
        .ar       (ar),
        .rvalid   (rvalid),
        .rready   (rready),
        .r        (r),
        .outValid (outValid),
        .outReady (outReady),
        .outInstr (outInstr),
        .pcWe     (pcWe),
        .pcWaddr  (pcWaddr),
        .pcWdata  (pcWdata)
    );

    pcFile pcFile_i (
        .clk   (clk),
        .rst   (rst),
        .we    (pcWe),
        .waddr (pcWaddr),
        .wdata (pcWdata),
        .rdReq (pcRead),
        .rdData(pcReadData)
    );

endmodule

/* hw/instrRam.sv */
`timescale 1ns/1ps

module instrRam #(
    parameter int RAM_WORDS = 256
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  arvalid,
    output logic                  arready,
    input  fetchPkg::AxiLiteAr_t  ar,
    output logic                  rvalid,
    input  logic                  rready,
    output fetchPkg::AxiLiteR_t   r,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic                  wvalid,
    output logic                  wready,
    input  fetchPkg::AxiLiteW_t   w,
    output logic                  bvalid,
    input  logic                  bready
);

    localparam int IDX_W = $clog2(RAM_WORDS);

    fetchPkg::Instr_t mem [RAM_WORDS];
    fetchPkg::Instr_t rdWord;

    logic [IDX_W-1:0] rdIdx;
    logic [IDX_W-1:0] wrIdx;
    logic             arFire;
    logic             wrAccept;

    assign arready = 1'b1;
    assign arFire  = arvalid && arready;
    assign rdIdx   = ar.araddr[IDX_W+1:2];
    assign r       = fetchPkg::AxiLiteR_t'{rdata: rdWord, rresp: fetchPkg::RESP_OKAY};

    // Read response is held until the master takes it
    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (arFire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (arFire) begin
            rdWord <= mem[rdIdx];
        end
    end

    // Address and data are taken together, one write in flight
    assign wrAccept = awvalid && wvalid && !bvalid;
    assign awready  = wrAccept;
    assign wready   = wrAccept;
    assign wrIdx    = w.awaddr[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
        end else if (wrAccept) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wrAccept) begin
            for (int i = 0; i < 4; i++) begin
                if (w.wstrb[i]) begin
                    mem[wrIdx][8*i +: 8] <= w.wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

/* hw/frontendTop.sv */
`timescale 1ns/1ps

module frontendTop #(
    parameter int BTB_ENTRIES = 8,
    parameter int RAM_WORDS   = 256,
    parameter int RESET_DELAY = 20
) (
    input  logic                  clk,
    input  logic                  rst,
    input  fetchPkg::Redirect_t   redirect,
    input  fetchPkg::BtbUpdate_t  btbUpd,
    input  logic                  intPending,
    output logic                  outValid,
    input  logic                  outReady,
    output fetchPkg::FetchOut_t   outInstr,
    input  fetchPkg::PcRead_t     pcRead,
    output fetchPkg::Addr_t       pcReadData,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic                  wvalid,
    output logic                  wready,
    input  fetchPkg::AxiLiteW_t   w,
    output logic                  bvalid,
    input  logic                  bready
);

    // Instruction read bus between fetch unit and RAM
    logic                 arvalid;
    logic                 arready;
    fetchPkg::AxiLiteAr_t ar;
    logic                 rvalid;
    logic                 rready;
    fetchPkg::AxiLiteR_t  r;

    iFetch #(
        .BTB_ENTRIES(BTB_ENTRIES),
        .RESET_DELAY(RESET_DELAY)
    ) iFetch_i (
        .clk       (clk),
        .rst       (rst),
        .intPending(intPending),
        .redirect  (redirect),
        .btbUpd    (btbUpd),
        .outValid  (outValid),
        .outReady  (outReady),
        .outInstr  (outInstr),
        .pcRead    (pcRead),
        .pcReadData(pcReadData),
        .arvalid   (arvalid),
        .arready   (arready),
        .ar        (ar),
        .rvalid    (rvalid),
        .rready    (rready),
        .r         (r)
    );

    instrRam #(
        .RAM_WORDS(RAM_WORDS)
    ) instrRam_i (
        .clk    (clk),
        .rst    (rst),
        .arvalid(arvalid),
        .arready(arready),
        .ar     (ar),
        .rvalid (rvalid),
        .rready (rready),
        .r      (r),
        .awvalid(awvalid),
        .awready(awready),
        .wvalid (wvalid),
        .wready (wready),
        .w      (w),
        .bvalid (bvalid),
        .bready (bready)
    );

endmodule

/* testbench/frontend_chk.sv */
`timescale 1ns/1ps

module frontend_chk (
    input logic                clk,
    input logic                rst,
    input logic                squash,
    input logic                outValid,
    input logic                outReady,
    input fetchPkg::FetchOut_t outInstr,
    input logic                arvalid,
    input logic                arready,
    input logic                rvalid,
    input logic                rready
);

    logic       arFire;
    logic       rFire;
    logic [1:0] outstanding;
    int         assertFails = 0;

    assign arFire = arvalid && arready;
    assign rFire  = rvalid && rready;

    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= '0;
        end else if (arFire && !rFire) begin
            outstanding <= outstanding + 2'd1;
        end else if (!arFire && rFire) begin
            outstanding <= outstanding - 2'd1;
        end
    end

    // Only a squash may drop the held item
    holdStable: assert property (@(posedge clk) disable iff (rst)
        outValid && !outReady && !squash |=> outValid && $stable(outInstr))
        else begin
            $error("output item changed under back-pressure");
            assertFails++;
        end

    arIdleAfterReset: assert property (@(posedge clk) rst |=> !arvalid)
        else begin
            $error("arvalid high right after reset");
            assertFails++;
        end

    singleRead: assert property (@(posedge clk) disable iff (rst)
        arFire |-> (outstanding == 2'd0) || rFire)
        else begin
            $error("second read issued while one is outstanding");
            assertFails++;
        end

endmodule

bind fetchPipeline frontend_chk chk_i (
    .clk     (clk),
    .rst     (rst),
    .squash  (squash),
    .outValid(outValid),
    .outReady(outReady),
    .outInstr(outInstr),
    .arvalid (arvalid),
    .arready (arready),
    .rvalid  (rvalid),
    .rready  (rready)
);

/* testbench/frontend_tb.sv */
`timescale 1ns/1ps

module frontend_tb;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    localparam int BTB_ENTRIES  = 8;
    localparam int RAM_WORDS    = 64;
    // Long enough to load the whole program before the first fetch
    localparam int RESET_DELAY  = 200;
    localparam logic [31:0] LFSR_SEED = 32'h2d2f4342;

    localparam int SEQ_COUNT    = 60;
    localparam int BTB_COUNT    = 24;
    localparam int REDIR_COUNT  = 24;
    localparam int TAIL_COUNT   = 20;
    localparam int TOTAL_INSTR  = SEQ_COUNT + BTB_COUNT + REDIR_COUNT + TAIL_COUNT + 8;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + RESET_DELAY + 40 * TOTAL_INSTR;

    logic                 clk;
    logic                 rst;
    fetchPkg::Redirect_t  redirect;
    fetchPkg::BtbUpdate_t btbUpd;
    logic                 intPending;
    logic                 outValid;
    logic                 outReady;
    fetchPkg::FetchOut_t  outInstr;
    fetchPkg::PcRead_t    pcRead;
    fetchPkg::Addr_t      pcReadData;
    logic                 awvalid;
    logic                 awready;
    logic                 wvalid;
    logic                 wready;
    fetchPkg::AxiLiteW_t  w;
    logic                 bvalid;
    logic                 bready;

    // Reference model state
    logic [31:0]        lfsrState = LFSR_SEED;
    fetchPkg::Instr_t   progMem [RAM_WORDS];
    logic               modelValid [BTB_ENTRIES] = '{default: 1'b0};
    fetchPkg::Addr_t    modelSrc [BTB_ENTRIES];
    fetchPkg::Addr_t    modelDst [BTB_ENTRIES];
    fetchPkg::Addr_t    pcHist [16];
    fetchPkg::Addr_t    expPc = fetchPkg::RESET_PC;
    fetchPkg::FetchId_t expId = '0;
    logic               intArmed = 1'b0;
    logic               intDone = 1'b0;
    int                 delivered = 0;
    int                 intCount = 0;
    int                 cycleCnt = 0;

    frontendTop #(
        .BTB_ENTRIES(BTB_ENTRIES),
        .RAM_WORDS  (RAM_WORDS),
        .RESET_DELAY(RESET_DELAY)
    ) dut_i (
        .clk       (clk),
        .rst       (rst),
        .redirect  (redirect),
        .btbUpd    (btbUpd),
        .intPending(intPending),
        .outValid  (outValid),
        .outReady  (outReady),
        .outInstr  (outInstr),
        .pcRead    (pcRead),
        .pcReadData(pcReadData),
        .awvalid   (awvalid),
        .awready   (awready),
        .wvalid    (wvalid),
        .wready    (wready),
        .w         (w),
        .bvalid    (bvalid),
        .bready    (bready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    function automatic logic takeBit();
        lfsrState = lfsrStep(lfsrState);
        return lfsrState[0];
    endfunction

    function automatic fetchPkg::Instr_t randWord();
        fetchPkg::Instr_t v;
        v = '0;
        for (int i = 0; i < 32; i++) begin
            v = {v[30:0], takeBit()};
        end
        return v;
    endfunction

    function automatic int btbIndex(input fetchPkg::Addr_t pc);
        return int'((pc >> 2) % BTB_ENTRIES);
    endfunction

    function automatic logic btbHit(input fetchPkg::Addr_t pc);
        int idx;
        idx = btbIndex(pc);
        return modelValid[idx] && (modelSrc[idx][31:2] == pc[31:2]);
    endfunction

    // Expected PC after a fetch at pc
    function automatic fetchPkg::Addr_t refNextPc(input fetchPkg::Addr_t pc);
        if (btbHit(pc)) begin
            return modelDst[btbIndex(pc)];
        end
        return pc + 32'd4;
    endfunction

    // Word address wraps over the RAM depth
    function automatic fetchPkg::Instr_t refWord(input fetchPkg::Addr_t pc);
        return progMem[(pc >> 2) % RAM_WORDS];
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "run aborted");
    endtask

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            failRun("value check failed");
        end
    endtask

    task automatic loadWord(input int idx, input fetchPkg::Instr_t data, input logic [3:0] strb);
        awvalid = 1'b1;
        wvalid  = 1'b1;
        w       = '{awaddr: fetchPkg::Addr_t'(idx * 4), wdata: data, wstrb: strb};
        @(posedge clk);
        while (!(awready && wready)) begin
            @(posedge clk);
        end
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                progMem[idx][8*b +: 8] = data[8*b +: 8];
            end
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (!bvalid) begin
            failRun("no write response one cycle after the write was accepted");
        end
        @(negedge clk);
    endtask

    task automatic waitDelivered(input int count);
        int target;
        target = delivered + count;
        while (delivered < target) begin
            @(negedge clk);
            outReady = takeBit();
        end
    endtask

    task automatic applyRedirect(input fetchPkg::Addr_t target, input fetchPkg::BtbUpdate_t upd);
        redirect = '{taken: 1'b1, dst: target};
        btbUpd   = upd;
        @(negedge clk);
        redirect = '0;
        btbUpd   = '0;
    endtask

    task automatic checkTransfer();
        fetchPkg::FetchOut_t got;
        got = outInstr;
        if (intDone) begin
            failRun("an instruction was delivered after the interrupt and before a redirect");
        end
        checkEq("outInstr.pc", got.pc, expPc);
        checkEq("outInstr.fetchId", got.fetchId, expId);
        checkEq("outInstr.predTaken", got.predTaken, btbHit(expPc));
        if (got.fault == fetchPkg::FAULT_INTERRUPT) begin
            if (!intArmed) begin
                failRun("an interrupt instruction arrived with no interrupt pending");
            end
            checkEq("outInstr.instr", got.instr, 32'h0);
            intDone = 1'b1;
            intCount++;
        end else begin
            checkEq("outInstr.fault", got.fault, fetchPkg::FAULT_NONE);
            checkEq("outInstr.instr", got.instr, refWord(expPc));
        end
        pcHist[expId] = expPc;
        delivered++;
        expPc = refNextPc(expPc);
        expId = expId + 4'd1;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            cycleCnt = 0;
        end else begin
            cycleCnt++;
            if (dut_i.iFetch_i.fetchPipeline_i.chk_i.assertFails != 0) begin
                failRun("an assertion on the fetch pipeline failed");
            end
            if (outValid && cycleCnt <= RESET_DELAY) begin
                failRun("outValid was raised inside the start-up delay");
            end
            if (outValid && outReady) begin
                checkTransfer();
            end
            // A transfer at the redirect edge still belongs to the old path
            if (redirect.taken) begin
                expPc    = redirect.dst;
                intArmed = 1'b0;
                intDone  = 1'b0;
            end
            if (btbUpd.valid) begin
                modelValid[btbIndex(btbUpd.src)] = 1'b1;
                modelSrc[btbIndex(btbUpd.src)]   = btbUpd.src;
                modelDst[btbIndex(btbUpd.src)]   = btbUpd.dst;
            end
            if (intPending) begin
                intArmed = 1'b1;
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        failRun("watchdog expired before the tests completed");
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        redirect   = '0;
        btbUpd     = '0;
        intPending = 1'b0;
        outReady   = 1'b0;
        pcRead     = '0;
        awvalid    = 1'b0;
        wvalid     = 1'b0;
        w          = '0;
        bready     = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        // Program load runs inside the start-up delay
        for (int i = 0; i < RAM_WORDS; i++) begin
            loadWord(i, randWord(), 4'hF);
        end
        loadWord(3, randWord(), 4'b0101);

        waitDelivered(SEQ_COUNT);

        // Train the BTB with 0x40 to 0x90 and restart just before it
        applyRedirect(32'h38, '{valid: 1'b1, src: 32'h40, dst: 32'h90});
        waitDelivered(BTB_COUNT);

        applyRedirect(32'hC0, '0);
        waitDelivered(REDIR_COUNT);

        intPending = 1'b1;
        while (intCount == 0) begin
            @(negedge clk);
            outReady = takeBit();
        end
        outReady = 1'b1;
        repeat (20) @(negedge clk);
        intPending = 1'b0;
        @(negedge clk);

        // Fetch is stopped here, so the PC file is quiet
        for (int id = 0; id < 16; id++) begin
            pcRead = '{valid: 1'b1, addr: fetchPkg::FetchId_t'(id)};
            @(posedge clk);
            checkEq("pcReadData", pcReadData, pcHist[id]);
            @(negedge clk);
        end
        pcRead = '0;

        applyRedirect(32'h10, '0);
        waitDelivered(TAIL_COUNT);

        $display("all tests passed");
        $finish;
    end

endmodule

/* build.f */
hw/fetchPkg.sv
hw/branchPredictor.sv
hw/pcFile.sv
hw/fetchPipeline.sv
hw/iFetch.sv
hw/instrRam.sv
hw/frontendTop.sv
testbench/frontend_chk.sv
testbench/frontend_tb.sv
